// ==== rtl/rx_pkg.sv ====
package rx_pkg;

  // width of one I or Q word on the CMOS bus
  localparam int sample_w = 12;

  // consecutive well-formed frame cycles required before lock is declared
  localparam int lock_run = 16;

  // run counter width, wide enough to reach lock_run - 1
  localparam int run_cnt_w = 5;

  // width of the sequence tag attached to each released beat
  localparam int seq_w = 8;

  // one complex sample as it leaves the DDR capture
  typedef struct packed {
    logic [sample_w-1:0] i;
    logic [sample_w-1:0] q;
  } iq_sample_t;

  // one output beat, both receive channels
  typedef struct packed {
    iq_sample_t ch0;
    iq_sample_t ch1;
  } rx_beat_t;

  // beat with its sequence number, as presented at the top level
  typedef struct packed {
    logic [seq_w-1:0] seq;
    rx_beat_t         beat;
  } tagged_beat_t;

  // frame pin seen in the two halves of one data_clk cycle
  typedef struct packed {
    logic first;
    logic second;
  } frame_bits_t;

  // alignment states of the frame FSM
  typedef enum logic [1:0] {
    search = 2'd0,
    locked = 2'd1
  } align_state_t;

endpackage

// ==== rtl/rx_ddr_capture.sv ====
module rx_ddr_capture (
  input  logic                        data_clk,
  input  logic                        arst_n,
  input  logic                        mimo,
  input  logic                        rx_frame,
  input  logic [rx_pkg::sample_w-1:0] rx_d,
  output rx_pkg::frame_bits_t         frame_status,
  output logic                        beat_strobe,
  output rx_pkg::rx_beat_t            beat
);

  import rx_pkg::*;

  logic [sample_w-1:0] rise_d;
  logic [sample_w-1:0] fall_d;
  logic                rise_frame;
  logic                fall_frame;
  iq_sample_t          pair;
  iq_sample_t          held;

  // the rising edge carries I and the first frame half
  always_ff @(posedge data_clk) begin
    rise_d <= rx_d;
  end

  always_ff @(posedge data_clk or negedge arst_n) begin
    if (!arst_n) begin
      rise_frame <= 1'b0;
    end else begin
      rise_frame <= rx_frame;
    end
  end

  // the falling edge carries Q and the second frame half
  always_ff @(negedge data_clk) begin
    fall_d <= rx_d;
  end

  always_ff @(negedge data_clk or negedge arst_n) begin
    if (!arst_n) begin
      fall_frame <= 1'b0;
    end else begin
      fall_frame <= rx_frame;
    end
  end

  // bring both halves onto the rising edge so one cycle holds one I/Q pair
  always_ff @(posedge data_clk) begin
    pair.i <= rise_d;
    pair.q <= fall_d;
  end

  always_ff @(posedge data_clk or negedge arst_n) begin
    if (!arst_n) begin
      frame_status <= '0;
    end else begin
      frame_status.first  <= rise_frame;
      frame_status.second <= fall_frame;
    end
  end

  // in 2R mode a beat closes on the frame-low half of the pair,
  // in 1R mode every aligned pair is a beat
  always_ff @(posedge data_clk or negedge arst_n) begin
    if (!arst_n) begin
      beat_strobe <= 1'b0;
    end else begin
      beat_strobe <= !mimo || !frame_status.first;
    end
  end

  always_ff @(posedge data_clk) begin
    if (mimo) begin
      if (frame_status.first) begin
        // channel 0 waits here for its channel 1 partner
        held <= pair;
      end else begin
        beat.ch0 <= held;
        beat.ch1 <= pair;
      end
    end else begin
      beat.ch0 <= pair;
      beat.ch1 <= pair;
    end
  end

endmodule

// ==== rtl/frame_align_fsm.sv ====
module frame_align_fsm (
  input  logic                data_clk,
  input  logic                arst_n,
  input  logic                mimo,
  input  rx_pkg::frame_bits_t frame_status,
  input  logic                run_done,
  output logic                run_clear,
  output logic                run_count_en,
  output logic                locked
);

  import rx_pkg::*;

  align_state_t state;
  align_state_t state_next;
  logic         prev_first;
  logic         mimo_q;
  logic         mode_change;
  logic         frame_good;

  // frame level and mode from the previous cycle
  always_ff @(posedge data_clk or negedge arst_n) begin
    if (!arst_n) begin
      prev_first <= 1'b0;
      mimo_q     <= 1'b0;
    end else begin
      prev_first <= frame_status.first;
      mimo_q     <= mimo;
    end
  end

  assign mode_change = mimo != mimo_q;

  // both halves must agree; 1R holds frame high, 2R toggles every cycle
  always_comb begin
    frame_good = frame_status.first == frame_status.second;
    if (mimo) begin
      frame_good = frame_good && (frame_status.first != prev_first);
    end else begin
      frame_good = frame_good && frame_status.first;
    end
    if (mode_change) begin
      frame_good = 1'b0;
    end
  end

  always_comb begin
    state_next   = state;
    run_clear    = 1'b0;
    run_count_en = 1'b0;
    case (state)
      rx_pkg::search: begin
        run_count_en = frame_good;
        run_clear    = !frame_good;
        if (frame_good && run_done) begin
          state_next = rx_pkg::locked;
        end
      end
      rx_pkg::locked: begin
        // one bad cycle is enough to distrust the capture again
        if (!frame_good) begin
          state_next = rx_pkg::search;
          run_clear  = 1'b1;
        end
      end
      default: begin
        state_next = rx_pkg::search;
        run_clear  = 1'b1;
      end
    endcase
  end

  always_ff @(posedge data_clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= rx_pkg::search;
    end else begin
      state <= state_next;
    end
  end

  // the enum member shares its name with the port, hence the scoped name
  assign locked = state == rx_pkg::locked;

endmodule

// ==== rtl/lock_run_counter.sv ====
module lock_run_counter (
  input  logic data_clk,
  input  logic arst_n,
  input  logic run_clear,
  input  logic run_count_en,
  output logic run_done
);

  import rx_pkg::*;

  logic [run_cnt_w-1:0] run_count;

  // terminal count is lock_run - 1, so the next good cycle completes the run
  assign run_done = run_count == run_cnt_w'(lock_run - 1);

  always_ff @(posedge data_clk or negedge arst_n) begin
    if (!arst_n) begin
      run_count <= '0;
    end else if (run_clear) begin
      run_count <= '0;
    end else if (run_count_en && !run_done) begin
      run_count <= run_count + 1'b1;
    end
  end

endmodule

// ==== rtl/rx_beat_output.sv ====
module rx_beat_output (
  input  logic                 data_clk,
  input  logic                 arst_n,
  input  logic                 locked,
  input  logic                 beat_strobe,
  input  rx_pkg::rx_beat_t     beat,
  output logic                 beat_valid,
  output rx_pkg::tagged_beat_t beat_out
);

  import rx_pkg::*;

  logic             locked_q;
  logic             lock_rise;
  logic             accept;
  logic [seq_w-1:0] seq_count;
  logic [seq_w-1:0] seq_now;

  always_ff @(posedge data_clk or negedge arst_n) begin
    if (!arst_n) begin
      locked_q <= 1'b0;
    end else begin
      locked_q <= locked;
    end
  end

  assign lock_rise = locked && !locked_q;
  assign accept    = beat_strobe && locked;

  // a beat arriving on the very first locked cycle still gets tag 0
  assign seq_now = lock_rise ? '0 : seq_count;

  always_ff @(posedge data_clk or negedge arst_n) begin
    if (!arst_n) begin
      seq_count  <= '0;
      beat_valid <= 1'b0;
    end else begin
      beat_valid <= accept;
      if (accept) begin
        seq_count <= seq_now + 1'b1;
      end else if (lock_rise) begin
        seq_count <= '0;
      end
    end
  end

  always_ff @(posedge data_clk) begin
    if (accept) begin
      beat_out.seq  <= seq_now;
      beat_out.beat <= beat;
    end
  end

endmodule

// ==== rtl/cmos_rx_top.sv ====
module cmos_rx_top (
  input  logic                        data_clk,
  input  logic                        arst_n,
  input  logic                        mimo,
  input  logic                        rx_frame,
  input  logic [rx_pkg::sample_w-1:0] rx_d,
  output logic                        locked,
  output logic                        beat_valid,
  output rx_pkg::tagged_beat_t        beat_out
);

  import rx_pkg::*;

  frame_bits_t frame_status;
  rx_beat_t    beat;
  logic        beat_strobe;
  logic        run_clear;
  logic        run_count_en;
  logic        run_done;

  rx_ddr_capture capture_i (
    .data_clk     (data_clk),
    .arst_n       (arst_n),
    .mimo         (mimo),
    .rx_frame     (rx_frame),
    .rx_d         (rx_d),
    .frame_status (frame_status),
    .beat_strobe  (beat_strobe),
    .beat         (beat)
  );

  frame_align_fsm align_i (
    .data_clk     (data_clk),
    .arst_n       (arst_n),
    .mimo         (mimo),
    .frame_status (frame_status),
    .run_done     (run_done),
    .run_clear    (run_clear),
    .run_count_en (run_count_en),
    .locked       (locked)
  );

  lock_run_counter run_cnt_i (
    .data_clk     (data_clk),
    .arst_n       (arst_n),
    .run_clear    (run_clear),
    .run_count_en (run_count_en),
    .run_done     (run_done)
  );

  rx_beat_output out_i (
    .data_clk    (data_clk),
    .arst_n      (arst_n),
    .locked      (locked),
    .beat_strobe (beat_strobe),
    .beat        (beat),
    .beat_valid  (beat_valid),
    .beat_out    (beat_out)
  );

endmodule

// ==== test/cmos_rx_tb.sv ====
module cmos_rx_tb;

  import rx_pkg::*;

  localparam int          clk_period   = 40;
  localparam int          reset_cycles = 5;
  localparam logic [15:0] lfsr_seed    = 16'd15098;

  // cycle budget of each phase; a lock wait is bounded by a 2R acquisition
  localparam int     lock_bound    = 2 * lock_run + 8;
  localparam int     beats_1r      = 40;
  localparam int     beats_err     = 10;
  localparam int     pairs_2r      = 30;
  localparam int     beats_back    = 20;
  localparam int     total_cycles  = reset_cycles + 4 * lock_bound + beats_1r + beats_err
                                     + 2 * pairs_2r + beats_back + 24;
  localparam longint watchdog_time = longint'(total_cycles + 50) * clk_period;

  logic                data_clk;
  logic                arst_n;
  logic                mimo;
  logic                rx_frame;
  logic [sample_w-1:0] rx_d;
  logic                locked;
  logic                beat_valid;
  tagged_beat_t        beat_out;

  logic [15:0]      lfsr_state;
  logic             pin_good;
  logic             mode_start;
  logic [1:0]       good_pipe;
  logic [1:0]       start_pipe;
  logic             bad_pins;
  logic             prev_mode;
  logic             prev_f1;
  int               good_run;
  logic             locked_seen;
  logic [seq_w-1:0] exp_seq;
  int               fail_count;
  string            test_name;

  cmos_rx_top dut_i (
    .data_clk   (data_clk),
    .arst_n     (arst_n),
    .mimo       (mimo),
    .rx_frame   (rx_frame),
    .rx_d       (rx_d),
    .locked     (locked),
    .beat_valid (beat_valid),
    .beat_out   (beat_out)
  );

  always #(clk_period / 2) data_clk = ~data_clk;

  task automatic fail_stop();
    fail_count++;
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic mismatch(input string what, input logic [63:0] exp, input logic [63:0] act);
    $display("[FAIL] %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
    fail_stop();
  endtask

  task automatic give_up(input string msg);
    $display("%s", msg);
    fail_stop();
  endtask

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_word(output logic [sample_w-1:0] w);
    w = '0;
    for (int b = 0; b < sample_w; b++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[sample_w-2:0], lfsr_state[0]};
    end
  endtask

  // I and frame-first go out before the sampling rising edge, Q and frame-second after it
  task automatic drive_cycle(input logic mode, input logic [sample_w-1:0] i,
                             input logic f1, input logic f2);
    logic good;
    good = (f1 == f2) && (mode ? (f1 != prev_f1) : f1);
    @(negedge data_clk);
    mimo       <= mode;
    rx_d       <= i;
    rx_frame   <= f1;
    pin_good   <= good;
    mode_start <= mode != prev_mode;
    bad_pins   <= f1 != f2;
    prev_mode = mode;
    prev_f1   = f1;
    @(posedge data_clk);
    rx_d     <= ~i;
    rx_frame <= f2;
  endtask

  task automatic run_1r(input int cycles);
    logic [sample_w-1:0] w;
    for (int n = 0; n < cycles; n++) begin
      random_word(w);
      drive_cycle(1'b0, w, 1'b1, 1'b1);
    end
  endtask

  // channel 1 carries the channel 0 word plus one
  task automatic run_2r(input int pairs);
    logic [sample_w-1:0] w;
    for (int n = 0; n < pairs; n++) begin
      random_word(w);
      drive_cycle(1'b1, w, 1'b1, 1'b1);
      drive_cycle(1'b1, w + 1'b1, 1'b0, 1'b0);
    end
  endtask

  // count consecutive well-formed frame cycles at the point where the FSM judges them
  // a change of mode starts a new run
  always @(posedge data_clk or negedge arst_n) begin
    if (!arst_n) begin
      good_pipe  <= '0;
      start_pipe <= '0;
      good_run   <= 0;
    end else begin
      good_pipe  <= {good_pipe[0], pin_good};
      start_pipe <= {start_pipe[0], mode_start};
      if (!good_pipe[1]) begin
        good_run <= 0;
      end else if (start_pipe[1]) begin
        good_run <= 1;
      end else if (good_run < 1000) begin
        good_run <= good_run + 1;
      end
    end
  end

  // expected tag restarts at every rise of locked
  always @(posedge data_clk or negedge arst_n) begin
    if (!arst_n) begin
      locked_seen <= 1'b0;
      exp_seq     <= '0;
    end else begin
      locked_seen <= locked;
      if (locked && !locked_seen) begin
        exp_seq <= '0;
      end else if (beat_valid) begin
        exp_seq <= exp_seq + seq_w'(1);
      end
    end
  end

  reset_quiet_a: assert property (@(posedge data_clk)
    (!arst_n || !$past(arst_n)) |-> (!locked && !beat_valid))
    else mismatch("outputs in reset", 64'(0), 64'({$sampled(locked), $sampled(beat_valid)}));

  lock_run_a: assert property (@(posedge data_clk) disable iff (!arst_n)
    $rose(locked) |-> good_run >= lock_run)
    else mismatch("good frame cycles before lock", 64'(lock_run), 64'($sampled(good_run)));

  ch0_iq_a: assert property (@(posedge data_clk) disable iff (!arst_n)
    beat_valid |-> beat_out.beat.ch0.q == ~beat_out.beat.ch0.i)
    else mismatch("ch0 q", 64'($sampled(~beat_out.beat.ch0.i)), 64'($sampled(beat_out.beat.ch0.q)));

  ch1_iq_a: assert property (@(posedge data_clk) disable iff (!arst_n)
    beat_valid |-> beat_out.beat.ch1.q == ~beat_out.beat.ch1.i)
    else mismatch("ch1 q", 64'($sampled(~beat_out.beat.ch1.i)), 64'($sampled(beat_out.beat.ch1.q)));

  // the beat was formed with the mode seen two edges before it shows up
  pair_1r_a: assert property (@(posedge data_clk) disable iff (!arst_n)
    beat_valid && !$past(mimo, 2) |-> beat_out.beat.ch1 == beat_out.beat.ch0)
    else mismatch("1R ch1", 64'($sampled(beat_out.beat.ch0)), 64'($sampled(beat_out.beat.ch1)));

  pair_2r_a: assert property (@(posedge data_clk) disable iff (!arst_n)
    beat_valid && $past(mimo, 2) |->
      beat_out.beat.ch1.i == sample_w'(beat_out.beat.ch0.i + 1'b1))
    else mismatch("2R ch1 i", 64'(sample_w'($sampled(beat_out.beat.ch0.i) + 1'b1)),
                  64'($sampled(beat_out.beat.ch1.i)));

  seq_a: assert property (@(posedge data_clk) disable iff (!arst_n)
    beat_valid |-> beat_out.seq == exp_seq)
    else mismatch("seq", 64'($sampled(exp_seq)), 64'($sampled(beat_out.seq)));

  spacing_2r_a: assert property (@(posedge data_clk) disable iff (!arst_n)
    beat_valid && $past(mimo, 2) |-> !$past(beat_valid))
    else mismatch("beat_valid on consecutive 2R cycles", 64'(0), 64'(1));

  valid_locked_a: assert property (@(posedge data_clk) disable iff (!arst_n)
    beat_valid |-> $past(locked))
    else mismatch("locked when beat accepted", 64'(1), 64'(0));

  err_hold_a: assert property (@(posedge data_clk) disable iff (!arst_n)
    $past(bad_pins, 2) && $past(locked, 2) |-> locked)
    else mismatch("locked one cycle after frame error", 64'(1), 64'($sampled(locked)));

  err_drop_a: assert property (@(posedge data_clk) disable iff (!arst_n)
    $past(bad_pins, 3) |-> !locked)
    else mismatch("locked two cycles after frame error", 64'(0), 64'($sampled(locked)));

  mode_drop_a: assert property (@(posedge data_clk) disable iff (!arst_n)
    $past(mimo) != $past(mimo, 2) |-> !locked)
    else mismatch("locked after mode change", 64'(0), 64'($sampled(locked)));

  initial begin
    #(watchdog_time);
    give_up($sformatf("watchdog expired during %s with the align FSM in state %s",
                      test_name, dut_i.align_i.state.name()));
  end

  initial begin : stimulus
    logic [sample_w-1:0] w;
    data_clk   = 1'b0;
    arst_n     = 1'b0;
    mimo       = 1'b0;
    rx_frame   = 1'b0;
    rx_d       = '0;
    pin_good   = 1'b0;
    mode_start = 1'b0;
    bad_pins   = 1'b0;
    prev_mode  = 1'b0;
    prev_f1    = 1'b0;
    fail_count = 0;
    lfsr_state = lfsr_seed;
    test_name  = "reset";
    repeat (reset_cycles) @(negedge data_clk);
    arst_n <= 1'b1;

    test_name = "lock_1r";
    while (!locked) begin
      run_1r(1);
    end
    run_1r(beats_1r);

    // one split frame cycle, then lock has to be found again
    test_name = "frame_error";
    random_word(w);
    drive_cycle(1'b0, w, 1'b1, 1'b0);
    run_1r(4);
    while (!locked) begin
      run_1r(1);
    end
    run_1r(beats_err);

    test_name = "mode_to_2r";
    run_2r(2);
    while (!locked) begin
      run_2r(1);
    end
    run_2r(pairs_2r);

    test_name = "mode_to_1r";
    run_1r(4);
    while (!locked) begin
      run_1r(1);
    end
    run_1r(beats_back);

    // the last beats still travel through the 3-cycle pipeline
    repeat (4) @(negedge data_clk);
    if (fail_count == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      fail_stop();
    end
  end

endmodule

// ==== cmos_rx.f ====
rtl/rx_pkg.sv
rtl/rx_ddr_capture.sv
rtl/frame_align_fsm.sv
rtl/lock_run_counter.sv
rtl/rx_beat_output.sv
rtl/cmos_rx_top.sv
test/cmos_rx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the cmos_rx testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cmos_rx_tb \
  -f cmos_rx.f -o cmos_rx_sim > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/cmos_rx_sim > sim.log 2>&1

grep -q "Test OK" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
